/* src/booth_pkg.sv */
// Booth operand definitions
package booth_pkg;

    // ----------------------------------------------------------------------
    // operand sizes
    // ----------------------------------------------------------------------

    // operand width
    localparam int OP_W = 32;

    // partial products, operand extended by two bits so unsigned fits
    localparam int NPP = (OP_W + 2) / 2;

    // one partial product covers -2m .. +2m
    localparam int PP_W = OP_W + 2;

    // ----------------------------------------------------------------------
    // radix-4 digit
    // ----------------------------------------------------------------------

    // recoded multiplier digit, one per window of three bits
    typedef enum logic [2:0] {
        BOOTH_ZERO,
        BOOTH_POS1,
        BOOTH_POS2,
        BOOTH_NEG1,
        BOOTH_NEG2
    } booth_op_e;

endpackage

/* src/tree_pkg.sv */
// Reduction tree definitions
package tree_pkg;

    // ----------------------------------------------------------------------
    // product rows
    // ----------------------------------------------------------------------

    // full product width
    localparam int PROD_W = 64;

    // one row, already aligned to its column weight
    typedef logic [PROD_W-1:0] row_t;

    // ----------------------------------------------------------------------
    // rows entering each tree level
    // ----------------------------------------------------------------------

    // 17 partial products plus the correction row
    localparam int ROWS_L0 = 18;
    localparam int ROWS_L1 = 10;
    localparam int ROWS_L2 = 6;
    localparam int ROWS_L3 = 4;

    // sum and carry rows into the final adder
    localparam int ROWS_OUT = 2;

    // enabled edges from operand capture to product
    localparam int LATENCY = 5;

endpackage

/* src/booth_pp_gen.sv */
// Booth partial product generator
`timescale 1ns/1ns

module booth_pp_gen (
    input  logic [booth_pkg::OP_W-1:0] multiplicand,
    input  logic [booth_pkg::OP_W-1:0] multiplier,
    input  logic                       signed_mode,
    output tree_pkg::row_t             rows [tree_pkg::ROWS_L0]
);

    logic [booth_pkg::PP_W-1:0] mcand_ext;
    // extended multiplier with the implicit zero below bit 0
    logic [booth_pkg::PP_W:0]   mplier_win;
    booth_pkg::booth_op_e       digit [booth_pkg::NPP];
    logic [booth_pkg::PP_W-1:0] pp [booth_pkg::NPP];
    logic [booth_pkg::NPP-1:0]  neg;
    tree_pkg::row_t             corr_row;

    // window {y[2i+1], y[2i], y[2i-1]} to digit
    function automatic booth_pkg::booth_op_e recode(input logic [2:0] win);
        booth_pkg::booth_op_e op;
        case (win)
            3'b001, 3'b010: op = booth_pkg::BOOTH_POS1;
            3'b011:         op = booth_pkg::BOOTH_POS2;
            3'b100:         op = booth_pkg::BOOTH_NEG2;
            3'b101, 3'b110: op = booth_pkg::BOOTH_NEG1;
            default:        op = booth_pkg::BOOTH_ZERO;
        endcase
        return op;
    endfunction

    // sign or zero extension by two bits
    assign mcand_ext  = {{2{signed_mode & multiplicand[booth_pkg::OP_W-1]}}, multiplicand};
    assign mplier_win = {{2{signed_mode & multiplier[booth_pkg::OP_W-1]}}, multiplier, 1'b0};

    // ----------------------------------------------------------------------
    // partial product rows
    // ----------------------------------------------------------------------

    for (genvar i = 0; i < booth_pkg::NPP; i++)
    begin : g_pp
        assign digit[i] = recode(mplier_win[2*i +: 3]);

        // negative multiples are one's complement here, +1 lands in the correction row
        always_comb
        begin
            case (digit[i])
                booth_pkg::BOOTH_POS1: pp[i] = mcand_ext;
                booth_pkg::BOOTH_POS2: pp[i] = {mcand_ext[booth_pkg::PP_W-2:0], 1'b0};
                booth_pkg::BOOTH_NEG1: pp[i] = ~mcand_ext;
                booth_pkg::BOOTH_NEG2: pp[i] = ~{mcand_ext[booth_pkg::PP_W-2:0], 1'b0};
                default:               pp[i] = '0;
            endcase
        end

        assign neg[i] = (digit[i] == booth_pkg::BOOTH_NEG1) ||
                        (digit[i] == booth_pkg::BOOTH_NEG2);

        // sign compression, top bit inverted and no extension bits
        assign rows[i] = tree_pkg::row_t'({~pp[i][booth_pkg::PP_W-1],
                                           pp[i][booth_pkg::PP_W-2:0]}) << (2 * i);
    end

    // ----------------------------------------------------------------------
    // correction row
    // ----------------------------------------------------------------------

    // negation bits at column 2i, minus 2^(PP_W-1+2i) per row for the
    // inverted sign bits; folds to a constant plus the neg bits
    always_comb
    begin
        corr_row = '0;
        for (int i = 0; i < booth_pkg::NPP; i++)
        begin
            corr_row = corr_row + (tree_pkg::row_t'(neg[i]) << (2 * i));
            corr_row = corr_row - (tree_pkg::row_t'(1) << (booth_pkg::PP_W - 1 + 2 * i));
        end
    end

    assign rows[tree_pkg::ROWS_L0-1] = corr_row;

endmodule

/* src/compressor_42.sv */
// Row-wide 4:2 compressor
`timescale 1ns/1ns

module compressor_42 (
    input  tree_pkg::row_t x1,
    input  tree_pkg::row_t x2,
    input  tree_pkg::row_t x3,
    input  tree_pkg::row_t x4,
    output tree_pkg::row_t sum,
    output tree_pkg::row_t carry
);

    tree_pkg::row_t s1;
    tree_pkg::row_t hor_cout;
    tree_pkg::row_t hor_cin;
    tree_pkg::row_t carry_raw;

    // first full adder per column
    assign s1       = x1 ^ x2 ^ x3;
    assign hor_cout = (x1 & x2) | (x1 & x3) | (x2 & x3);

    // horizontal carry into the next column up, top one drops out
    assign hor_cin = {hor_cout[tree_pkg::PROD_W-2:0], 1'b0};

    // second full adder per column
    assign sum       = s1 ^ x4 ^ hor_cin;
    assign carry_raw = (s1 & x4) | (s1 & hor_cin) | (x4 & hor_cin);

    // carry row carries weight of the next column
    assign carry = {carry_raw[tree_pkg::PROD_W-2:0], 1'b0};

endmodule

/* src/reduction_level.sv */
// Registered reduction tree level
`timescale 1ns/1ns

module reduction_level #(
    parameter  int N_IN  = 4,
    // two rows per full group of four, leftovers pass through
    localparam int N_OUT = 2 * (N_IN / 4) + (N_IN % 4)
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           run,
    input  logic           valid_in,
    input  tree_pkg::row_t rows_in [N_IN],
    output logic           valid_out,
    output tree_pkg::row_t rows_out [N_OUT]
);

    localparam int N_GRP = N_IN / 4;
    localparam int N_REM = N_IN % 4;

    tree_pkg::row_t rows_nxt [N_OUT];

    // ----------------------------------------------------------------------
    // compression of full groups
    // ----------------------------------------------------------------------

    for (genvar g = 0; g < N_GRP; g++)
    begin : g_cmp
        compressor_42 u_cmp (
            .x1    (rows_in[4*g]),
            .x2    (rows_in[4*g+1]),
            .x3    (rows_in[4*g+2]),
            .x4    (rows_in[4*g+3]),
            .sum   (rows_nxt[2*g]),
            .carry (rows_nxt[2*g+1])
        );
    end

    // leftover rows
    for (genvar r = 0; r < N_REM; r++)
    begin : g_pass
        assign rows_nxt[2*N_GRP+r] = rows_in[4*N_GRP+r];
    end

    // ----------------------------------------------------------------------
    // level registers
    // ----------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
            valid_out <= 1'b0;
        else if (run)
            valid_out <= valid_in;
    end

    always_ff @(posedge clk)
    begin
        if (run)
            rows_out <= rows_nxt;
    end

endmodule

/* src/final_adder.sv */
// Registered carry-lookahead final adder
`timescale 1ns/1ns

module final_adder (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         run,
    input  logic                         valid_in,
    input  tree_pkg::row_t               sum_row,
    input  tree_pkg::row_t               carry_row,
    output logic [tree_pkg::PROD_W-1:0]  product,
    output logic                         valid
);

    // four-bit groups
    localparam int N_GRP = tree_pkg::PROD_W / 4;

    tree_pkg::row_t   gen;
    tree_pkg::row_t   prop;
    tree_pkg::row_t   cbit;
    logic [N_GRP-1:0] grp_g;
    logic [N_GRP-1:0] grp_p;
    // top entry is the carry out, not used
    logic [N_GRP:0]   cgrp;

    assign gen  = sum_row & carry_row;
    assign prop = sum_row ^ carry_row;

    always_comb
    begin
        cgrp[0] = 1'b0;
        for (int k = 0; k < N_GRP; k++)
        begin
            grp_g[k] = gen[4*k+3] | (prop[4*k+3] & gen[4*k+2])
                     | (prop[4*k+3] & prop[4*k+2] & gen[4*k+1])
                     | (prop[4*k+3] & prop[4*k+2] & prop[4*k+1] & gen[4*k]);
            grp_p[k] = &prop[4*k +: 4];
            cgrp[k+1] = grp_g[k] | (grp_p[k] & cgrp[k]);

            // bit carries inside the group from its group carry
            cbit[4*k]   = cgrp[k];
            cbit[4*k+1] = gen[4*k] | (prop[4*k] & cgrp[k]);
            cbit[4*k+2] = gen[4*k+1] | (prop[4*k+1] & gen[4*k])
                        | (prop[4*k+1] & prop[4*k] & cgrp[k]);
            cbit[4*k+3] = gen[4*k+2] | (prop[4*k+2] & gen[4*k+1])
                        | (prop[4*k+2] & prop[4*k+1] & gen[4*k])
                        | (prop[4*k+2] & prop[4*k+1] & prop[4*k] & cgrp[k]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            valid <= 1'b0;
        else if (run)
            valid <= valid_in;
    end

    always_ff @(posedge clk)
    begin
        if (run)
            product <= prop ^ cbit;
    end

endmodule

/* src/booth_wallace_mul.sv */
// Pipelined Booth Wallace multiplier
`timescale 1ns/1ns

module booth_wallace_mul (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        run,
    input  logic                        in_valid,
    input  logic                        signed_mode,
    input  logic [booth_pkg::OP_W-1:0]  multiplicand,
    input  logic [booth_pkg::OP_W-1:0]  multiplier,
    output logic [tree_pkg::PROD_W-1:0] product,
    output logic                        out_valid
);

    tree_pkg::row_t rows_l0 [tree_pkg::ROWS_L0];
    tree_pkg::row_t rows_l1 [tree_pkg::ROWS_L1];
    tree_pkg::row_t rows_l2 [tree_pkg::ROWS_L2];
    tree_pkg::row_t rows_l3 [tree_pkg::ROWS_L3];
    tree_pkg::row_t rows_fin [tree_pkg::ROWS_OUT];

    logic valid_l1;
    logic valid_l2;
    logic valid_l3;
    logic valid_fin;

    // ----------------------------------------------------------------------
    // partial products, combinational
    // ----------------------------------------------------------------------

    booth_pp_gen u_pp_gen (
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .signed_mode  (signed_mode),
        .rows         (rows_l0)
    );

    // ----------------------------------------------------------------------
    // tree, one register per level
    // ----------------------------------------------------------------------

    // 18 -> 10, captures the operation
    reduction_level #(.N_IN(tree_pkg::ROWS_L0)) u_level0 (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .valid_in  (in_valid),
        .rows_in   (rows_l0),
        .valid_out (valid_l1),
        .rows_out  (rows_l1)
    );

    // 10 -> 6
    reduction_level #(.N_IN(tree_pkg::ROWS_L1)) u_level1 (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .valid_in  (valid_l1),
        .rows_in   (rows_l1),
        .valid_out (valid_l2),
        .rows_out  (rows_l2)
    );

    // 6 -> 4
    reduction_level #(.N_IN(tree_pkg::ROWS_L2)) u_level2 (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .valid_in  (valid_l2),
        .rows_in   (rows_l2),
        .valid_out (valid_l3),
        .rows_out  (rows_l3)
    );

    // 4 -> 2
    reduction_level #(.N_IN(tree_pkg::ROWS_L3)) u_level3 (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .valid_in  (valid_l3),
        .rows_in   (rows_l3),
        .valid_out (valid_fin),
        .rows_out  (rows_fin)
    );

    final_adder u_final_adder (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .valid_in  (valid_fin),
        .sum_row   (rows_fin[0]),
        .carry_row (rows_fin[1]),
        .product   (product),
        .valid     (out_valid)
    );

endmodule

/* sim/tb_model.svh */
// Multiplier reference model
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ----------------------------------------------------------------------
// random source
// ----------------------------------------------------------------------

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
endfunction

// ----------------------------------------------------------------------
// reference product
// ----------------------------------------------------------------------

// full-width product of the extended operands, wraps at 2^64
function automatic logic [tree_pkg::PROD_W-1:0] model_product(
    input logic [booth_pkg::OP_W-1:0] a,
    input logic [booth_pkg::OP_W-1:0] b,
    input logic                       sm
);
    logic [tree_pkg::PROD_W-1:0] a_ext;
    logic [tree_pkg::PROD_W-1:0] b_ext;
    if (sm)
    begin
        a_ext = {{(tree_pkg::PROD_W - booth_pkg::OP_W){a[booth_pkg::OP_W-1]}}, a};
        b_ext = {{(tree_pkg::PROD_W - booth_pkg::OP_W){b[booth_pkg::OP_W-1]}}, b};
    end
    else
    begin
        a_ext = {{(tree_pkg::PROD_W - booth_pkg::OP_W){1'b0}}, a};
        b_ext = {{(tree_pkg::PROD_W - booth_pkg::OP_W){1'b0}}, b};
    end
    // low half of a 128-bit product is the same for signed and unsigned
    return a_ext * b_ext;
endfunction

`endif

/* sim/tb_booth_wallace_mul.sv */
// Booth multiplier testbench
`timescale 1ns/1ns

module tb_booth_wallace_mul;

    localparam int          TIMEOUT_CYCLES = 1500;
    localparam logic [31:0] LFSR_SEED      = 32'd38;
    localparam int          N_RANDOM       = 200;
    localparam int          N_STALL_OPS    = 60;
    localparam int          N_BUBBLE       = 40;

    logic                        clk;
    logic                        rst;
    logic                        run;
    logic                        in_valid;
    logic                        signed_mode;
    logic [booth_pkg::OP_W-1:0]  multiplicand;
    logic [booth_pkg::OP_W-1:0]  multiplier;
    logic [tree_pkg::PROD_W-1:0] product;
    logic                        out_valid;

    `include "tb_model.svh"

    // scoreboard with one entry per accepted operation
    logic [tree_pkg::PROD_W-1:0] exp_q [$];
    int                          edge_q [$];
    string                       name_q [$];

    int                          edges_en;
    int                          issues;
    int                          results;
    int                          value_errs;
    int                          other_errs;
    logic [31:0]                 lfsr_state;
    logic [tree_pkg::PROD_W-1:0] last_product;
    logic                        last_valid;

    booth_wallace_mul UUT (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .in_valid     (in_valid),
        .signed_mode  (signed_mode),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .product      (product),
        .out_valid    (out_valid)
    );

    always #5 clk = ~clk;

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------

    // one LFSR step per bit
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // check the outputs of the edge just taken at the falling edge
    task automatic score_edge(input logic r, input logic v, input logic sm,
                              input logic [31:0] a, input logic [31:0] b, input string name);
        logic expect_valid;
        if (r)
        begin
            edges_en++;
            if (v)
            begin
                exp_q.push_back(model_product(a, b, sm));
                edge_q.push_back(edges_en);
                name_q.push_back(name);
                issues++;
            end
            // result due exactly LATENCY enabled edges after capture
            expect_valid = (edge_q.size() > 0) &&
                           (edge_q[0] == edges_en - tree_pkg::LATENCY + 1);
            assert (out_valid === expect_valid)
            else
            begin
                other_errs++;
                if (expect_valid)
                    $display("out_valid low at enabled edge %0d, %s result missing",
                             edges_en, name_q[0]);
                else
                    $display("out_valid high at enabled edge %0d with no result due (%s)",
                             edges_en, name);
            end
            if (out_valid === 1'b1)
                results++;
            if (expect_valid)
            begin
                if (out_valid === 1'b1)
                begin
                    assert (product === exp_q[0])
                    else
                    begin
                        value_errs++;
                        $display("FAIL %s: expected %h, actual %h", name_q[0], exp_q[0], product);
                    end
                end
                void'(exp_q.pop_front());
                void'(edge_q.pop_front());
                void'(name_q.pop_front());
            end
        end
        else
        begin
            // frozen pipeline
            assert ((out_valid === last_valid) && (product === last_product))
            else
            begin
                other_errs++;
                $display("outputs changed while run was low (%s)", name);
            end
        end
        last_valid   = out_valid;
        last_product = product;
    endtask

    // drive on the falling edge and score at the next one
    task automatic apply_cycle(input logic r, input logic v, input logic sm,
                               input logic [31:0] a, input logic [31:0] b, input string name);
        run          = r;
        in_valid     = v;
        signed_mode  = sm;
        multiplicand = a;
        multiplier   = b;
        @(posedge clk);
        @(negedge clk);
        score_edge(r, v, sm, a, b, name);
    endtask

    task automatic drain_pipeline();
        while (edge_q.size() > 0)
        begin
            apply_cycle(1'b1, 1'b0, 1'b0, '0, '0, "drain");
        end
        apply_cycle(1'b1, 1'b0, 1'b0, '0, '0, "drain");
    endtask

    // ------------------------------------------------------------------
    // test sequences
    // ------------------------------------------------------------------

    task automatic unsigned_corners();
        apply_cycle(1'b1, 1'b1, 1'b0, 32'h0000_0000, 32'hdead_beef, "unsigned zero");
        apply_cycle(1'b1, 1'b1, 1'b0, 32'hdead_beef, 32'h0000_0000, "unsigned zero");
        apply_cycle(1'b1, 1'b1, 1'b0, 32'h0000_0001, 32'hffff_ffff, "unsigned one max");
        apply_cycle(1'b1, 1'b1, 1'b0, 32'hffff_ffff, 32'hffff_ffff, "unsigned max max");
        apply_cycle(1'b1, 1'b1, 1'b0, 32'h8000_0000, 32'hffff_ffff, "unsigned pow2 max");
        apply_cycle(1'b1, 1'b1, 1'b0, 32'h0001_0000, 32'hffff_ffff, "unsigned pow2 max");
        drain_pipeline();
    endtask

    task automatic signed_corners();
        apply_cycle(1'b1, 1'b1, 1'b1, 32'h8000_0000, 32'h8000_0000, "signed min min");
        apply_cycle(1'b1, 1'b1, 1'b1, 32'h8000_0000, 32'hffff_ffff, "signed min neg1");
        apply_cycle(1'b1, 1'b1, 1'b1, 32'hffff_ffff, 32'hffff_ffff, "signed neg1 neg1");
        apply_cycle(1'b1, 1'b1, 1'b1, 32'h8000_0000, 32'h7fff_ffff, "signed min max");
        apply_cycle(1'b1, 1'b1, 1'b1, 32'hffff_fffd, 32'h0000_0007, "signed mixed");
        apply_cycle(1'b1, 1'b1, 1'b1, 32'h0000_3039, 32'hffff_e57b, "signed mixed");
        drain_pipeline();
    endtask

    task automatic random_stream();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] m;
        for (int n = 0; n < N_RANDOM; n++)
        begin
            draw_bits(32, a);
            draw_bits(32, b);
            draw_bits(1, m);
            apply_cycle(1'b1, 1'b1, m[0], a, b, "random");
        end
        drain_pipeline();
    endtask

    task automatic stall_stream();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] m;
        logic [31:0] pick;
        logic [31:0] len;
        for (int n = 0; n < N_STALL_OPS; n++)
        begin
            draw_bits(2, pick);
            if (pick == 0)
            begin
                draw_bits(3, len);
                // in_valid may be high here but none of it counts
                for (int s = 0; s <= len; s++)
                begin
                    draw_bits(1, m);
                    draw_bits(32, a);
                    draw_bits(32, b);
                    apply_cycle(1'b0, m[0], 1'b1, a, b, "stall");
                end
            end
            draw_bits(32, a);
            draw_bits(32, b);
            draw_bits(1, m);
            apply_cycle(1'b1, 1'b1, m[0], a, b, "stall");
        end
        drain_pipeline();
    endtask

    task automatic bubble_stream();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        for (int n = 0; n < N_BUBBLE; n++)
        begin
            draw_bits(1, v);
            draw_bits(32, a);
            draw_bits(32, b);
            apply_cycle(1'b1, v[0], 1'b1, a, b, "bubbles");
        end
        drain_pipeline();
    endtask

    // reset while operations are in flight and run is low
    task automatic reset_in_flight();
        for (int n = 0; n < tree_pkg::LATENCY; n++)
        begin
            apply_cycle(1'b1, 1'b1, n[0], 32'h0000_1000 + n, 32'hffff_fff0 - n, "reset flush");
        end
        // reset wins over run
        rst      = 1'b1;
        run      = 1'b0;
        in_valid = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        assert (out_valid === 1'b0)
        else
        begin
            other_errs++;
            $display("out_valid not low after reset with operations in flight");
        end
        // flushed operations never come out
        issues = issues - exp_q.size();
        exp_q.delete();
        edge_q.delete();
        name_q.delete();
        last_valid   = out_valid;
        last_product = product;
        repeat (tree_pkg::LATENCY)
        begin
            apply_cycle(1'b1, 1'b0, 1'b0, '0, '0, "reset flush");
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------

    initial
    begin
        clk          = 1'b0;
        rst          = 1'b1;
        run          = 1'b1;
        in_valid     = 1'b0;
        signed_mode  = 1'b0;
        multiplicand = '0;
        multiplier   = '0;
        lfsr_state   = LFSR_SEED;
        edges_en     = 0;
        issues       = 0;
        results      = 0;
        value_errs   = 0;
        other_errs   = 0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (out_valid === 1'b0)
        else
        begin
            other_errs++;
            $display("out_valid not low after reset");
        end
        last_valid   = out_valid;
        last_product = product;

        apply_cycle(1'b1, 1'b0, 1'b0, '0, '0, "reset idle");
        apply_cycle(1'b1, 1'b0, 1'b0, '0, '0, "reset idle");

        unsigned_corners();
        signed_corners();
        random_stream();
        stall_stream();
        bubble_stream();
        reset_in_flight();

        assert (results == issues)
        else
        begin
            other_errs++;
            $display("saw %0d results for %0d issued operations", results, issues);
        end

        $display("errors: %0d value, %0d other (%0d results, %0d issues)",
                 value_errs, other_errs, results, issues);
        if (value_errs + other_errs == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // watchdog
    initial
    begin : watchdog
        int cyc;
        cyc = 0;
        while (cyc < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cyc++;
        end
        $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d value, %0d other", value_errs, other_errs);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* src.f */
+incdir+sim
src/booth_pkg.sv
src/tree_pkg.sv
src/booth_pp_gen.sv
src/compressor_42.sv
src/reduction_level.sv
src/final_adder.sv
src/booth_wallace_mul.sv
sim/tb_booth_wallace_mul.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Verilator build and run of the multiplier testbench
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
    -f src.f \
    --top-module tb_booth_wallace_mul \
    --Mdir obj_dir

out="$(./obj_dir/Vtb_booth_wallace_mul)"
echo "$out"

if grep -qx "Done: no errors" <<< "$out"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
